// File: source/video_pkg.sv
/* Video definitions for the output path
   Pixel layout and the fixed OSD palette */
package video_pkg;

    localparam int COLOR_W = 8;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } pixel_t;

    // OSD palette index
    typedef enum logic [1:0] {
        OSD_BLACK,
        OSD_BLUE,
        OSD_YELLOW,
        OSD_WHITE
    } osd_color_e;

    localparam pixel_t OSD_RGB_BLACK  = '{r: '0, g: '0, b: '0};
    localparam pixel_t OSD_RGB_BLUE   = '{r: '0, g: '0, b: '1};
    localparam pixel_t OSD_RGB_YELLOW = '{r: '1, g: '1, b: '0};
    localparam pixel_t OSD_RGB_WHITE  = '{r: '1, g: '1, b: '1};

endpackage

// File: source/board_ctrl_pkg.sv
/* Board control definitions
   Source select and PWM duty encoding */
package board_ctrl_pkg;

    // Capture source
    typedef enum logic {
        SRC_DIGITIZER,
        SRC_HDMIRX
    } src_sel_e;

    // Duty in sixteenths of the period
    typedef logic [3:0] duty_t;

    localparam int DUTY_STEPS = 16;

endpackage

// File: source/video_capture_mux.sv
/* Capture mux that registers the selected source with its OSD request
   and flags the start of each frame */
`timescale 1ns/1ns

module video_capture_mux
    import video_pkg::*;
    import board_ctrl_pkg::*;
(
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  src_sel_e   src_sel_i,
    input  pixel_t     dig_pixel_i,
    input  logic       dig_hsync_i,
    input  logic       dig_vsync_i,
    input  logic       dig_de_i,
    input  logic       dig_datavalid_i,
    input  pixel_t     rx_pixel_i,
    input  logic       rx_hsync_i,
    input  logic       rx_vsync_i,
    input  logic       rx_de_i,
    input  logic       osd_enable_i,
    input  osd_color_e osd_color_i,
    output pixel_t     cap_pixel_o,
    output logic       cap_hsync_o,
    output logic       cap_vsync_o,
    output logic       cap_de_o,
    output logic       cap_osd_enable_o,
    output osd_color_e cap_osd_color_o,
    output logic       frame_start_o
);

    logic vsync_prev;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cap_pixel_o      <= '0;
            cap_hsync_o      <= 1'b0;
            cap_vsync_o      <= 1'b0;
            cap_de_o         <= 1'b0;
            cap_osd_enable_o <= 1'b0;
            cap_osd_color_o  <= OSD_BLACK;
            vsync_prev       <= 1'b0;
            frame_start_o    <= 1'b0;
        end else begin
            if (src_sel_i == SRC_HDMIRX) begin
                cap_pixel_o <= rx_pixel_i;
                cap_hsync_o <= rx_hsync_i;
                cap_vsync_o <= rx_vsync_i;
                cap_de_o    <= rx_de_i;
            end else begin
                cap_pixel_o <= dig_pixel_i;
                cap_hsync_o <= dig_hsync_i;
                cap_vsync_o <= dig_vsync_i;
                // Digitizer DE only counts on valid samples
                cap_de_o    <= dig_de_i & dig_datavalid_i;
            end
            cap_osd_enable_o <= osd_enable_i;
            cap_osd_color_o  <= osd_color_i;

            // Vsync falling edge with hsync low
            vsync_prev    <= cap_vsync_o;
            frame_start_o <= vsync_prev & ~cap_vsync_o & ~cap_hsync_o;
        end
    end

endmodule

// File: source/osd_blender.sv
/* OSD blender that replaces the pixel with a palette color
   while the on-screen display is active */
`timescale 1ns/1ns

module osd_blender
    import video_pkg::*;
(
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  pixel_t     cap_pixel_i,
    input  logic       cap_hsync_i,
    input  logic       cap_vsync_i,
    input  logic       cap_de_i,
    input  logic       cap_osd_enable_i,
    input  osd_color_e cap_osd_color_i,
    output pixel_t     blend_pixel_o,
    output logic       blend_hsync_o,
    output logic       blend_vsync_o,
    output logic       blend_de_o
);

    pixel_t osd_pixel;

    always_comb begin
        case (cap_osd_color_i)
            OSD_BLUE:   osd_pixel = OSD_RGB_BLUE;
            OSD_YELLOW: osd_pixel = OSD_RGB_YELLOW;
            OSD_WHITE:  osd_pixel = OSD_RGB_WHITE;
            default:    osd_pixel = OSD_RGB_BLACK;
        endcase
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            blend_pixel_o <= '0;
            blend_hsync_o <= 1'b0;
            blend_vsync_o <= 1'b0;
            blend_de_o    <= 1'b0;
        end else begin
            blend_pixel_o <= cap_osd_enable_i ? osd_pixel : cap_pixel_i;
            // Syncs kept aligned with the pixel
            blend_hsync_o <= cap_hsync_i;
            blend_vsync_o <= cap_vsync_i;
            blend_de_o    <= cap_de_i;
        end
    end

endmodule

// File: source/tx_output_stage.sv
/* Final register bank in front of the HDMI transmitter pins */
`timescale 1ns/1ns

module tx_output_stage
    import video_pkg::*;
(
    input  logic   pclk_out,
    input  logic   po_reset_n,
    input  pixel_t blend_pixel_i,
    input  logic   blend_hsync_i,
    input  logic   blend_vsync_i,
    input  logic   blend_de_i,
    output pixel_t hdmitx_pixel_o,
    output logic   hdmitx_hsync_o,
    output logic   hdmitx_vsync_o,
    output logic   hdmitx_de_o
);

    // Pin-facing retiming of 24 data bits plus 3 control bits
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmitx_pixel_o <= '0;
            hdmitx_hsync_o <= 1'b0;
            hdmitx_vsync_o <= 1'b0;
            hdmitx_de_o    <= 1'b0;
        end else begin
            hdmitx_pixel_o <= blend_pixel_i;
            hdmitx_hsync_o <= blend_hsync_i;
            hdmitx_vsync_o <= blend_vsync_i;
            hdmitx_de_o    <= blend_de_i;
        end
    end

endmodule

// File: source/pwm_2ch.sv
/* Two-channel PWM for fan and LED, gated by system power */
`timescale 1ns/1ns

module pwm_2ch
    import board_ctrl_pkg::*;
#(
    parameter int PWM_PERIOD = 1024
) (
    input  logic  pclk_out,
    input  logic  po_reset_n,
    input  logic  sys_poweron_i,
    input  duty_t fan_duty_i,
    input  duty_t led_duty_i,
    output logic  fan_pwm_o,
    output logic  led_pwm_o
);

    localparam int CNT_W = $clog2(PWM_PERIOD);
    localparam int STEP  = PWM_PERIOD / DUTY_STEPS;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] fan_thresh;
    logic [CNT_W-1:0] led_thresh;
    logic             fan_ch;
    logic             led_ch;

    assign fan_thresh = CNT_W'(fan_duty_i * STEP);
    assign led_thresh = CNT_W'(led_duty_i * STEP);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cnt    <= '0;
            fan_ch <= 1'b0;
            led_ch <= 1'b0;
        end else begin
            cnt    <= (cnt == CNT_W'(PWM_PERIOD - 1)) ? '0 : cnt + 1'b1;
            fan_ch <= cnt < fan_thresh;
            led_ch <= cnt < led_thresh;
        end
    end

    // Fan driver is active low
    assign fan_pwm_o = ~(fan_ch & sys_poweron_i);
    assign led_pwm_o = led_ch & sys_poweron_i;

endmodule

// File: source/scan_out_top.sv
/* Scan converter output path from the capture mux through OSD and TX stage
   plus the fan and LED PWM */
`timescale 1ns/1ns

module scan_out_top
    import video_pkg::*;
    import board_ctrl_pkg::*;
#(
    parameter int PWM_PERIOD = 1024
) (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  src_sel_e   src_sel_i,
    input  pixel_t     dig_pixel_i,
    input  logic       dig_hsync_i,
    input  logic       dig_vsync_i,
    input  logic       dig_de_i,
    input  logic       dig_datavalid_i,
    input  pixel_t     rx_pixel_i,
    input  logic       rx_hsync_i,
    input  logic       rx_vsync_i,
    input  logic       rx_de_i,
    input  logic       osd_enable_i,
    input  osd_color_e osd_color_i,
    input  logic       sys_poweron_i,
    input  duty_t      fan_duty_i,
    input  duty_t      led_duty_i,
    output pixel_t     hdmitx_pixel_o,
    output logic       hdmitx_hsync_o,
    output logic       hdmitx_vsync_o,
    output logic       hdmitx_de_o,
    output logic       frame_start_o,
    output logic       fan_pwm_o,
    output logic       led_pwm_o
);

    pixel_t     cap_pixel;
    logic       cap_hsync;
    logic       cap_vsync;
    logic       cap_de;
    logic       cap_osd_enable;
    osd_color_e cap_osd_color;

    pixel_t     blend_pixel;
    logic       blend_hsync;
    logic       blend_vsync;
    logic       blend_de;

    video_capture_mux u_capture (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .src_sel_i        (src_sel_i),
        .dig_pixel_i      (dig_pixel_i),
        .dig_hsync_i      (dig_hsync_i),
        .dig_vsync_i      (dig_vsync_i),
        .dig_de_i         (dig_de_i),
        .dig_datavalid_i  (dig_datavalid_i),
        .rx_pixel_i       (rx_pixel_i),
        .rx_hsync_i       (rx_hsync_i),
        .rx_vsync_i       (rx_vsync_i),
        .rx_de_i          (rx_de_i),
        .osd_enable_i     (osd_enable_i),
        .osd_color_i      (osd_color_i),
        .cap_pixel_o      (cap_pixel),
        .cap_hsync_o      (cap_hsync),
        .cap_vsync_o      (cap_vsync),
        .cap_de_o         (cap_de),
        .cap_osd_enable_o (cap_osd_enable),
        .cap_osd_color_o  (cap_osd_color),
        .frame_start_o    (frame_start_o)
    );

    osd_blender u_osd (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .cap_pixel_i      (cap_pixel),
        .cap_hsync_i      (cap_hsync),
        .cap_vsync_i      (cap_vsync),
        .cap_de_i         (cap_de),
        .cap_osd_enable_i (cap_osd_enable),
        .cap_osd_color_i  (cap_osd_color),
        .blend_pixel_o    (blend_pixel),
        .blend_hsync_o    (blend_hsync),
        .blend_vsync_o    (blend_vsync),
        .blend_de_o       (blend_de)
    );

    tx_output_stage u_tx (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .blend_pixel_i  (blend_pixel),
        .blend_hsync_i  (blend_hsync),
        .blend_vsync_i  (blend_vsync),
        .blend_de_i     (blend_de),
        .hdmitx_pixel_o (hdmitx_pixel_o),
        .hdmitx_hsync_o (hdmitx_hsync_o),
        .hdmitx_vsync_o (hdmitx_vsync_o),
        .hdmitx_de_o    (hdmitx_de_o)
    );

    pwm_2ch #(
        .PWM_PERIOD (PWM_PERIOD)
    ) u_pwm (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .sys_poweron_i (sys_poweron_i),
        .fan_duty_i    (fan_duty_i),
        .led_duty_i    (led_duty_i),
        .fan_pwm_o     (fan_pwm_o),
        .led_pwm_o     (led_pwm_o)
    );

endmodule

// File: testbench/scan_out_chk.sv
/* Bound checker for the scan-out top level covering the frame strobe,
   PWM power gating and reset state */
`timescale 1ns/1ns

module scan_out_chk (
    input logic pclk_out,
    input logic po_reset_n,
    input logic frame_start_o,
    input logic sys_poweron_i,
    input logic fan_pwm_o,
    input logic led_pwm_o,
    input logic hdmitx_de_o
);

    int assert_fails = 0;

    // Strobe lasts a single cycle
    a_strobe_single: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        frame_start_o |=> !frame_start_o)
        else begin
            assert_fails++;
            $error("frame_start_o high on two consecutive cycles");
        end

    a_fan_off: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        !sys_poweron_i |-> fan_pwm_o)
        else begin
            assert_fails++;
            $error("fan_pwm_o low while power is off");
        end

    a_led_off: assert property (@(posedge pclk_out)
        !sys_poweron_i |-> !led_pwm_o)
        else begin
            assert_fails++;
            $error("led_pwm_o high while power is off");
        end

    a_de_reset: assert property (@(posedge pclk_out)
        !po_reset_n |-> !hdmitx_de_o)
        else begin
            assert_fails++;
            $error("hdmitx_de_o high during reset");
        end

endmodule

bind scan_out_top scan_out_chk u_chk (
    .pclk_out      (pclk_out),
    .po_reset_n    (po_reset_n),
    .frame_start_o (frame_start_o),
    .sys_poweron_i (sys_poweron_i),
    .fan_pwm_o     (fan_pwm_o),
    .led_pwm_o     (led_pwm_o),
    .hdmitx_de_o   (hdmitx_de_o)
);

// File: testbench/tb_scan_out.sv
/* Testbench for the scan-out path with file-driven video vectors,
   random pixels and PWM duty windows */
`timescale 1ns/1ns

module tb_scan_out
    import video_pkg::*;
    import board_ctrl_pkg::*;
();

    localparam int PWM_TB_PERIOD = 64;
    localparam int N_RANDOM      = 16;

    typedef struct {
        string      name;
        src_sel_e   sel;
        pixel_t     dig_pix;
        logic       dig_hs;
        logic       dig_vs;
        logic       dig_de;
        logic       dig_dv;
        pixel_t     rx_pix;
        logic       rx_hs;
        logic       rx_vs;
        logic       rx_de;
        logic       osd_en;
        osd_color_e osd_col;
        pixel_t     exp_pix;
        logic       exp_hs;
        logic       exp_vs;
        logic       exp_de;
        logic       exp_fs;
    } vec_t;

    logic       pclk_out;
    logic       po_reset_n;
    src_sel_e   src_sel_i;
    pixel_t     dig_pixel_i;
    logic       dig_hsync_i;
    logic       dig_vsync_i;
    logic       dig_de_i;
    logic       dig_datavalid_i;
    pixel_t     rx_pixel_i;
    logic       rx_hsync_i;
    logic       rx_vsync_i;
    logic       rx_de_i;
    logic       osd_enable_i;
    osd_color_e osd_color_i;
    logic       sys_poweron_i;
    duty_t      fan_duty_i;
    duty_t      led_duty_i;
    pixel_t     hdmitx_pixel_o;
    logic       hdmitx_hsync_o;
    logic       hdmitx_vsync_o;
    logic       hdmitx_de_o;
    logic       frame_start_o;
    logic       fan_pwm_o;
    logic       led_pwm_o;

    vec_t vecs[$];
    bit   vec_ok[];
    int   seed          = 32'h76211844;
    int   pass_cnt      = 0;
    int   fail_cnt      = 0;
    int   cycle_cnt     = 0;
    int   timeout_limit = 1000000;

    scan_out_top #(
        .PWM_PERIOD (PWM_TB_PERIOD)
    ) UUT (.*);

    initial begin
        pclk_out = 1'b0;
        forever #2 pclk_out = ~pclk_out;
    end

    always @(posedge pclk_out) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Palette colors by OSD index
    function automatic pixel_t palette_rgb(input osd_color_e c);
        case (c)
            OSD_BLUE:   return 24'h0000ff;
            OSD_YELLOW: return 24'hffff00;
            OSD_WHITE:  return 24'hffffff;
            default:    return 24'h000000;
        endcase
    endfunction

    task automatic check_pixel(input string name, input string what, input pixel_t exp,
                               input pixel_t act, inout bit ok);
        if (act !== exp) begin
            $display("Fail %s %s: expected %06h, actual %06h", name, what, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act, inout bit ok);
        if (act !== exp) begin
            $display("Fail %s %s: expected %b, actual %b", name, what, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act, inout bit ok);
        if (act != exp) begin
            $display("Fail %s %s: expected %0d, actual %0d", name, what, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_cnt++;
            $display("Test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("Test %s: failed", name);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        int          sel, dhs, dvs, dde, ddv, rhs, rvs, rde;
        int          oen, ocol, ehs, evs, ede, efs;
        logic [23:0] dpix, rpix, epix;
        vec_t        v;
        fd = $fopen("testbench/scan_out_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file testbench/scan_out_input.txt");
            fail_cnt++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, sel, dpix, dhs, dvs, dde, ddv, rpix, rhs, rvs, rde,
                                oen, ocol, epix, ehs, evs, ede, efs);
                    if (n == 18) begin
                        v.name    = name;
                        v.sel     = src_sel_e'(sel[0]);
                        v.dig_pix = dpix;
                        v.dig_hs  = dhs[0];
                        v.dig_vs  = dvs[0];
                        v.dig_de  = dde[0];
                        v.dig_dv  = ddv[0];
                        v.rx_pix  = rpix;
                        v.rx_hs   = rhs[0];
                        v.rx_vs   = rvs[0];
                        v.rx_de   = rde[0];
                        v.osd_en  = oen[0];
                        v.osd_col = osd_color_e'(ocol[1:0]);
                        v.exp_pix = epix;
                        v.exp_hs  = ehs[0];
                        v.exp_vs  = evs[0];
                        v.exp_de  = ede[0];
                        v.exp_fs  = efs[0];
                        vecs.push_back(v);
                    end else begin
                        $display("Malformed stimulus line skipped: %s", line);
                        fail_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Random pixels with expectations from the mux, gating and palette rules
    task automatic add_random_vectors();
        vec_t        v;
        logic [31:0] r;
        logic [31:0] p;
        logic        prev_vs;
        pixel_t      sel_pix;
        prev_vs = 1'b0;
        if (vecs.size() > 0) begin
            prev_vs = vecs[vecs.size()-1].exp_vs;
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            r         = $random(seed);
            v.name    = $sformatf("random_%0d", i);
            v.sel     = src_sel_e'(r[0]);
            v.osd_en  = r[1];
            v.osd_col = osd_color_e'(r[3:2]);
            v.dig_hs  = r[4];
            v.dig_vs  = r[5];
            v.dig_de  = r[6];
            v.dig_dv  = r[7];
            v.rx_hs   = r[8];
            v.rx_vs   = r[9];
            v.rx_de   = r[10];
            p         = $random(seed);
            v.dig_pix = p[23:0];
            p         = $random(seed);
            v.rx_pix  = p[23:0];
            if (v.sel == SRC_HDMIRX) begin
                v.exp_hs = v.rx_hs;
                v.exp_vs = v.rx_vs;
                v.exp_de = v.rx_de;
                sel_pix  = v.rx_pix;
            end else begin
                v.exp_hs = v.dig_hs;
                v.exp_vs = v.dig_vs;
                v.exp_de = v.dig_de & v.dig_dv;
                sel_pix  = v.dig_pix;
            end
            v.exp_pix = v.osd_en ? palette_rgb(v.osd_col) : sel_pix;
            v.exp_fs  = prev_vs & ~v.exp_vs & ~v.exp_hs;
            prev_vs   = v.exp_vs;
            vecs.push_back(v);
        end
    endtask

    task automatic drive_vector(input vec_t v);
        src_sel_i       <= v.sel;
        dig_pixel_i     <= v.dig_pix;
        dig_hsync_i     <= v.dig_hs;
        dig_vsync_i     <= v.dig_vs;
        dig_de_i        <= v.dig_de;
        dig_datavalid_i <= v.dig_dv;
        rx_pixel_i      <= v.rx_pix;
        rx_hsync_i      <= v.rx_hs;
        rx_vsync_i      <= v.rx_vs;
        rx_de_i         <= v.rx_de;
        osd_enable_i    <= v.osd_en;
        osd_color_i     <= v.osd_col;
    endtask

    task automatic check_reset_state();
        bit ok;
        ok = 1'b1;
        @(negedge pclk_out);
        check_pixel("reset_state", "pixel", 24'h000000, hdmitx_pixel_o, ok);
        check_bit("reset_state", "hsync", 1'b0, hdmitx_hsync_o, ok);
        check_bit("reset_state", "vsync", 1'b0, hdmitx_vsync_o, ok);
        check_bit("reset_state", "de", 1'b0, hdmitx_de_o, ok);
        check_bit("reset_state", "frame_start", 1'b0, frame_start_o, ok);
        check_bit("reset_state", "fan_pwm", 1'b1, fan_pwm_o, ok);
        check_bit("reset_state", "led_pwm", 1'b0, led_pwm_o, ok);
        report_test("reset_state", ok);
    endtask

    // One vector per cycle with the strobe due 2 cycles and the pixel 3 cycles later
    task automatic run_video();
        int nvec;
        int k;
        bit ok;
        nvec = vecs.size();
        for (int j = 0; j < nvec + 3; j++) begin
            @(posedge pclk_out);
            if (j < nvec) begin
                drive_vector(vecs[j]);
            end
            @(negedge pclk_out);
            k = j - 2;
            if (k >= 0 && k < nvec) begin
                ok = vec_ok[k];
                check_bit(vecs[k].name, "frame_start", vecs[k].exp_fs, frame_start_o, ok);
                vec_ok[k] = ok;
            end
            k = j - 3;
            if (k >= 0) begin
                ok = vec_ok[k];
                check_pixel(vecs[k].name, "pixel", vecs[k].exp_pix, hdmitx_pixel_o, ok);
                check_bit(vecs[k].name, "hsync", vecs[k].exp_hs, hdmitx_hsync_o, ok);
                check_bit(vecs[k].name, "vsync", vecs[k].exp_vs, hdmitx_vsync_o, ok);
                check_bit(vecs[k].name, "de", vecs[k].exp_de, hdmitx_de_o, ok);
                report_test(vecs[k].name, ok);
            end
        end
    endtask

    task automatic run_pwm(input string name, input duty_t fan_duty, input duty_t led_duty,
                           input logic power);
        int fan_low;
        int led_high;
        int step;
        bit ok;
        fan_low  = 0;
        led_high = 0;
        ok       = 1'b1;
        step     = PWM_TB_PERIOD / 16;
        @(posedge pclk_out);
        fan_duty_i    <= fan_duty;
        led_duty_i    <= led_duty;
        sys_poweron_i <= power;
        // Let the new duty reach the channel registers
        repeat (2) @(posedge pclk_out);
        repeat (PWM_TB_PERIOD) begin
            @(negedge pclk_out);
            if (!fan_pwm_o) fan_low++;
            if (led_pwm_o) led_high++;
        end
        check_count(name, "fan low cycles", power ? int'(fan_duty) * step : 0, fan_low, ok);
        check_count(name, "led high cycles", power ? int'(led_duty) * step : 0, led_high, ok);
        report_test(name, ok);
    endtask

    initial begin
        po_reset_n      = 1'b0;
        src_sel_i       = SRC_DIGITIZER;
        dig_pixel_i     = '0;
        dig_hsync_i     = 1'b0;
        dig_vsync_i     = 1'b0;
        dig_de_i        = 1'b0;
        dig_datavalid_i = 1'b0;
        rx_pixel_i      = '0;
        rx_hsync_i      = 1'b0;
        rx_vsync_i      = 1'b0;
        rx_de_i         = 1'b0;
        osd_enable_i    = 1'b0;
        osd_color_i     = OSD_BLACK;
        sys_poweron_i   = 1'b0;
        fan_duty_i      = '0;
        led_duty_i      = '0;
        load_vectors();
        if (vecs.size() == 0) begin
            $display("No stimulus vectors were loaded");
            fail_cnt++;
        end
        add_random_vectors();
        timeout_limit = vecs.size() + 4 * PWM_TB_PERIOD + 100;
        vec_ok = new[vecs.size()];
        foreach (vec_ok[i]) vec_ok[i] = 1'b1;
        repeat (8) @(posedge pclk_out);
        po_reset_n <= 1'b1;
        check_reset_state();
        run_video();
        run_pwm("pwm_fan5_led15", 4'd5, 4'd15, 1'b1);
        run_pwm("pwm_fan15_led0", 4'd15, 4'd0, 1'b1);
        run_pwm("pwm_fan0_led5", 4'd0, 4'd5, 1'b1);
        run_pwm("pwm_power_off", 4'd15, 4'd15, 1'b0);
        if (UUT.u_chk.assert_fails != 0) begin
            $display("The bound assertions failed %0d times", UUT.u_chk.assert_fails);
            fail_cnt++;
        end
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/scan_out_input.txt
# name sel dig_pix dig_hs dig_vs dig_de dig_dv rx_pix rx_hs rx_vs rx_de osd_en osd_col
# exp_pix exp_hs exp_vs exp_de exp_fs, all hex, sel 0 is the digitizer and 1 the HDMI receiver
dig_pass_a      0 123456 0 0 1 1 abcdef 1 1 1 0 0 123456 0 0 1 0
dig_pass_b      0 a5a5a5 1 0 1 1 5a5a5a 0 1 0 0 0 a5a5a5 1 0 1 0
dig_dv_low      0 00ff00 0 0 1 0 ffffff 1 1 1 0 0 00ff00 0 0 0 0
dig_de_low      0 102030 0 0 0 1 ffffff 1 1 1 0 0 102030 0 0 0 0
dig_vs_high     0 405060 1 1 1 1 000000 0 0 0 0 0 405060 1 1 1 0
rx_pass_a       1 111111 0 0 1 1 778899 1 0 1 0 0 778899 1 0 1 0
rx_pass_b       1 111111 0 0 1 1 0a0b0c 0 1 0 0 0 0a0b0c 0 1 0 0
rx_de_no_dv     1 222222 0 0 0 0 fedcba 0 1 1 0 0 fedcba 0 1 1 0
rx_fs_edge      1 333333 0 0 1 0 135790 0 0 1 0 0 135790 0 0 1 1
rx_after_fs     1 333333 0 0 1 0 246801 0 0 1 0 0 246801 0 0 1 0
osd_black       0 ffffff 0 0 1 1 000000 0 0 0 1 0 000000 0 0 1 0
osd_blue        0 808080 0 0 1 1 000000 0 0 0 1 1 0000ff 0 0 1 0
osd_yellow      1 000000 0 0 0 0 123123 0 0 1 1 2 ffff00 0 0 1 0
osd_white       1 000000 0 0 0 0 000000 0 0 1 1 3 ffffff 0 0 1 0
osd_off         1 000000 0 0 0 0 c0ffee 0 0 1 0 3 c0ffee 0 0 1 0
fs_vs_high      0 010101 0 1 1 1 000000 0 0 0 0 0 010101 0 1 1 0
fs_dig_edge     0 020202 0 0 1 1 000000 0 0 0 0 0 020202 0 0 1 1
fs_after_edge   0 030303 0 0 1 1 000000 0 0 0 0 0 030303 0 0 1 0
fs_vs_high_b    0 040404 1 1 1 1 000000 0 0 0 0 0 040404 1 1 1 0
fs_hs_high      0 050505 1 0 1 1 000000 0 0 0 0 0 050505 1 0 1 0
fs_vs_high_c    0 060606 0 1 0 1 000000 0 0 0 0 0 060606 0 1 0 0
fs_dv_low_edge  0 070707 0 0 1 0 000000 0 0 0 0 0 070707 0 0 0 1
rx_vs_high      1 000000 0 0 0 0 080808 0 1 1 0 0 080808 0 1 1 0
fs_switch_dig   0 090909 0 0 1 1 0a0a0a 0 1 1 0 0 090909 0 0 1 1
idle_a          0 000000 0 0 0 0 000000 0 0 0 0 0 000000 0 0 0 0
vs_toggle_a     0 0b0b0b 0 1 1 1 000000 0 0 0 0 0 0b0b0b 0 1 1 0
vs_toggle_b     0 0c0c0c 0 0 1 1 000000 0 0 0 0 0 0c0c0c 0 0 1 1
vs_toggle_c     0 0d0d0d 0 1 1 1 000000 0 0 0 0 0 0d0d0d 0 1 1 0
vs_toggle_d     0 0e0e0e 0 0 1 1 000000 0 0 0 0 0 0e0e0e 0 0 1 1
osd_dv_low      0 999999 0 0 1 0 000000 0 0 0 1 2 ffff00 0 0 0 0
rx_hsync        1 000000 0 0 0 0 abcdef 1 0 0 0 0 abcdef 1 0 0 0
idle_end        0 000000 0 0 0 0 000000 0 0 0 0 0 000000 0 0 0 0
rx_white_sync   1 000000 0 0 0 0 445566 1 1 1 1 3 ffffff 1 1 1 0
fs_to_idle      0 000000 0 0 0 0 000000 0 0 0 0 0 000000 0 0 0 1

// File: scan_out.f
source/video_pkg.sv
source/board_ctrl_pkg.sv
source/video_capture_mux.sv
source/osd_blender.sv
source/tx_output_stage.sv
source/pwm_2ch.sv
source/scan_out_top.sv
testbench/scan_out_chk.sv
testbench/tb_scan_out.sv

// File: Makefile
# Verilator build and run of the scan-out testbench

TOP = tb_scan_out
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f scan_out.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) && echo "Result: passed" || \
		(echo "Result: failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
